/* files.f */
+incdir+rtl
rtl/div_pkg.sv
rtl/div_apb_decode.sv
rtl/div_iter_ctrl.sv
rtl/div_iter_dpath.sv
rtl/div_result_sign.sv
rtl/div_apb_top.sv
verification/div_tb.sv

/* rtl/div_apb_decode.sv */
// apb register block for the divide unit
// holds operands and op code, issues start, returns status and results

`timescale 1ns/1ps
`include "div_defines.svh"

module div_apb_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`DIV_ADDR_W-1:0] paddr,
  input  logic [`DIV_W-1:0]      pwdata,
  output logic [`DIV_W-1:0]      prdata,
  output logic                   pslverr,
  input  logic                   busy,
  input  logic                   done,
  input  logic                   dz,
  input  logic [`DIV_W-1:0]      quot,
  input  logic [`DIV_W-1:0]      rem,
  output logic                   start,
  output logic [`DIV_W-1:0]      opa,
  output logic [`DIV_W-1:0]      opb,
  output div_pkg::div_op_e       op
);

  // ----------------------------------------------------------------------
  // access decode
  // ----------------------------------------------------------------------

  logic access;
  logic wr_access;
  logic sel_opa;
  logic sel_opb;
  logic sel_ctrl;
  logic sel_quot;
  logic sel_rem;
  logic mapped;
  logic start_req;
  logic err_ro;
  logic err_busy;
  logic [`DIV_W-1:0] status;

  // access cycle of a transfer, no wait states
  assign access    = psel && penable;
  assign wr_access = access && pwrite;

  assign sel_opa  = (paddr == `DIV_REG_OPA);
  assign sel_opb  = (paddr == `DIV_REG_OPB);
  assign sel_ctrl = (paddr == `DIV_REG_CTRL);
  assign sel_quot = (paddr == `DIV_REG_QUOT);
  assign sel_rem  = (paddr == `DIV_REG_REM);
  assign mapped   = sel_opa || sel_opb || sel_ctrl || sel_quot || sel_rem;

  // control write asking for a new division
  assign start_req = sel_ctrl && pwdata[`DIV_CTRL_START];

  // results are read only
  assign err_ro   = pwrite && (sel_quot || sel_rem);
  // engine cannot take a second division
  assign err_busy = pwrite && start_req && busy;

  assign pslverr = access && (!mapped || err_ro || err_busy);

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  // operands, free to change during a run, engine samples them in LOAD
  always_ff @(posedge clk) begin
    if (wr_access && sel_opa) begin
      opa <= pwdata;
    end
    if (wr_access && sel_opb) begin
      opb <= pwdata;
    end
  end

  // start pulse goes high the cycle after the write completes
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
      op    <= div_pkg::DIV_UNSIGNED;
    end else begin
      start <= wr_access && start_req && !busy;
      // refused start leaves the op code alone
      if (wr_access && sel_ctrl && !err_busy) begin
        op <= div_pkg::div_op_e'(pwdata[`DIV_CTRL_SIGNED]);
      end
    end
  end

  // ----------------------------------------------------------------------
  // read data
  // ----------------------------------------------------------------------

  always_comb begin
    status = '0;
    status[`DIV_STAT_BUSY] = busy;
    status[`DIV_STAT_DONE] = done;
    status[`DIV_STAT_DZ]   = dz;
  end

  // zero outside a read access cycle and for unmapped offsets
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        `DIV_REG_OPA:  prdata = opa;
        `DIV_REG_OPB:  prdata = opb;
        `DIV_REG_CTRL: prdata = status;
        `DIV_REG_QUOT: prdata = quot;
        `DIV_REG_REM:  prdata = rem;
        default:       prdata = '0;
      endcase
    end
  end

  // master must hold psel through the access cycle
  a_penable_psel : assert property (@(posedge clk) disable iff (reset)
    penable |-> psel);

endmodule

/* rtl/div_apb_top.sv */
// iterative 32-bit divide unit with apb register access
// register block, engine control and datapath, result stage

`timescale 1ns/1ps
`include "div_defines.svh"

module div_apb_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`DIV_ADDR_W-1:0] paddr,
  input  logic [`DIV_W-1:0]      pwdata,
  output logic [`DIV_W-1:0]      prdata,
  output logic                   pslverr
);

  // decode and engine handshake
  logic start;
  logic busy;

  // operands
  logic [`DIV_W-1:0] opa;
  logic [`DIV_W-1:0] opb;
  div_pkg::div_op_e  op;

  // engine sequencing
  logic load;
  logic step;
  logic iter_done;

  // datapath to result stage
  logic [`DIV_W-1:0] quot_mag;
  logic [`DIV_W-1:0] rem_mag;
  logic              neg_quot;
  logic              neg_rem;
  logic              div_zero;

  // held results
  logic [`DIV_W-1:0] quot;
  logic [`DIV_W-1:0] rem;
  logic              done;
  logic              dz;

  div_apb_decode u_decode (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
    .busy(busy), .done(done), .dz(dz), .quot(quot), .rem(rem),
    .start(start), .opa(opa), .opb(opb), .op(op)
  );

  div_iter_ctrl u_ctrl (
    .clk(clk), .reset(reset), .start(start), .busy(busy),
    .load(load), .step(step), .iter_done(iter_done)
  );

  div_iter_dpath u_dpath (
    .clk(clk), .reset(reset), .load(load), .step(step),
    .opa(opa), .opb(opb), .op(op), .quot_mag(quot_mag), .rem_mag(rem_mag),
    .neg_quot(neg_quot), .neg_rem(neg_rem), .div_zero(div_zero)
  );

  div_result_sign u_result (
    .clk(clk), .reset(reset), .start(start), .iter_done(iter_done),
    .quot_mag(quot_mag), .rem_mag(rem_mag), .neg_quot(neg_quot),
    .neg_rem(neg_rem), .div_zero(div_zero),
    .quot(quot), .rem(rem), .done(done), .dz(dz)
  );

endmodule

/* rtl/div_defines.svh */
// divide unit constants
// data and address widths, register map and bit positions

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// ------------------------------------------------------------------------
// widths
// ------------------------------------------------------------------------

// operand, quotient and remainder width
`define DIV_W 32

// apb byte address width, covers the five registers
`define DIV_ADDR_W 5

// ------------------------------------------------------------------------
// register offsets
// ------------------------------------------------------------------------

`define DIV_REG_OPA  5'h00
`define DIV_REG_OPB  5'h04
`define DIV_REG_CTRL 5'h08
`define DIV_REG_QUOT 5'h0C
`define DIV_REG_REM  5'h10

// control word bits, write side of CTRL
`define DIV_CTRL_START  0
`define DIV_CTRL_SIGNED 1

// status bits, read side of CTRL
`define DIV_STAT_BUSY 0
`define DIV_STAT_DONE 1
`define DIV_STAT_DZ   2

`endif

/* rtl/div_iter_ctrl.sv */
// divide engine control
// sequences load, 32 restoring steps and the hand-off to the result stage

`timescale 1ns/1ps

module div_iter_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic load,
  output logic step,
  output logic iter_done
);

  div_pkg::div_state_e state;
  div_pkg::div_state_e state_next;

  // counts steps taken in CALC, 31 marks the last one
  logic [4:0] iter_cnt;

  // ----------------------------------------------------------------------
  // state and counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= div_pkg::IDLE;
      iter_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == div_pkg::LOAD) begin
        iter_cnt <= '0;
      end else if (state == div_pkg::CALC) begin
        iter_cnt <= iter_cnt + 5'd1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      div_pkg::IDLE: begin
        if (start) begin
          state_next = div_pkg::LOAD;
        end
      end
      // operands captured this cycle
      div_pkg::LOAD: state_next = div_pkg::CALC;
      div_pkg::CALC: begin
        if (iter_cnt == 5'd31) begin
          state_next = div_pkg::DONE;
        end
      end
      // single hand-off cycle, result stage captures on the way out
      div_pkg::DONE: state_next = div_pkg::IDLE;
      default:       state_next = div_pkg::IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // outputs, decoded straight from state
  // ----------------------------------------------------------------------

  assign busy      = (state != div_pkg::IDLE);
  assign load      = (state == div_pkg::LOAD);
  assign step      = (state == div_pkg::CALC);
  assign iter_done = (state == div_pkg::DONE);

  // decode only starts the engine while busy is low
  a_start_idle : assert property (@(posedge clk) disable iff (reset)
    start |-> state == div_pkg::IDLE);

  // one run is a load, 32 steps, one done cycle, then back to idle
  a_run_shape : assert property (@(posedge clk) disable iff (reset)
    load |=> step [*32] ##1 iter_done ##1 (state == div_pkg::IDLE));

endmodule

/* rtl/div_iter_dpath.sv */
// divide engine datapath
// magnitude conversion and a restoring shift/subtract on a 65-bit register

`timescale 1ns/1ps
`include "div_defines.svh"

module div_iter_dpath (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              step,
  input  logic [`DIV_W-1:0] opa,
  input  logic [`DIV_W-1:0] opb,
  input  div_pkg::div_op_e  op,
  output logic [`DIV_W-1:0] quot_mag,
  output logic [`DIV_W-1:0] rem_mag,
  output logic              neg_quot,
  output logic              neg_rem,
  output logic              div_zero
);

  // remainder in [64:32], quotient in [31:0]
  logic [2*`DIV_W:0] rq;
  logic [`DIV_W-1:0] divisor;
  // unconverted dividend, needed for the divide-by-zero remainder
  logic [`DIV_W-1:0] dividend;

  logic              sign_a;
  logic              sign_b;
  logic [`DIV_W-1:0] mag_a;
  logic [`DIV_W-1:0] mag_b;
  logic [2*`DIV_W:0] rq_shift;
  logic [2*`DIV_W:0] div_ext;
  logic [2*`DIV_W:0] diff;

  // ----------------------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------------------

  assign sign_a = (op == div_pkg::DIV_SIGNED) && opa[`DIV_W-1];
  assign sign_b = (op == div_pkg::DIV_SIGNED) && opb[`DIV_W-1];

  // most negative value maps onto itself, read as unsigned it is right
  assign mag_a = sign_a ? (~opa + 1'b1) : opa;
  assign mag_b = sign_b ? (~opb + 1'b1) : opb;

  // ----------------------------------------------------------------------
  // restoring step
  // ----------------------------------------------------------------------

  assign rq_shift = {rq[2*`DIV_W-1:0], 1'b0};
  assign div_ext  = {1'b0, divisor, {`DIV_W{1'b0}}};
  // top bit set only when the partial remainder is below the divisor
  assign diff     = rq_shift - div_ext;

  always_ff @(posedge clk) begin
    if (load) begin
      rq       <= {{(`DIV_W+1){1'b0}}, mag_a};
      divisor  <= mag_b;
      dividend <= opa;
    end else if (step) begin
      if (diff[2*`DIV_W]) begin
        // restore, shifted value already carries quotient bit 0
        rq <= rq_shift;
      end else begin
        rq <= {diff[2*`DIV_W:1], 1'b1};
      end
    end
  end

  // sign and zero flags for the result stage
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_quot <= 1'b0;
      neg_rem  <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      neg_quot <= sign_a ^ sign_b;
      neg_rem  <= sign_a;
      div_zero <= (opb == '0);
    end
  end

  assign quot_mag = rq[`DIV_W-1:0];
  assign rem_mag  = div_zero ? dividend : rq[2*`DIV_W-1:`DIV_W];

endmodule

/* rtl/div_pkg.sv */
// divide unit shared types
// engine states and the operation code used across the divider

package div_pkg;

  // ----------------------------------------------------------------------
  // engine states
  // ----------------------------------------------------------------------

  // idle until start, load operands, 32 shift/subtract steps, one hand-off cycle
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    LOAD = 2'd1,
    CALC = 2'd2,
    DONE = 2'd3
  } div_state_e;

  // ----------------------------------------------------------------------
  // operation code
  // ----------------------------------------------------------------------

  // taken from the signed bit of the control word
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_op_e;

endpackage

/* rtl/div_result_sign.sv */
// divide result stage
// fixes signs, applies the divide-by-zero rule and holds the result

`timescale 1ns/1ps
`include "div_defines.svh"

module div_result_sign (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic              iter_done,
  input  logic [`DIV_W-1:0] quot_mag,
  input  logic [`DIV_W-1:0] rem_mag,
  input  logic              neg_quot,
  input  logic              neg_rem,
  input  logic              div_zero,
  output logic [`DIV_W-1:0] quot,
  output logic [`DIV_W-1:0] rem,
  output logic              done,
  output logic              dz
);

  logic [`DIV_W-1:0] quot_fix;
  logic [`DIV_W-1:0] rem_fix;

  // divide by zero gives all ones, remainder is the dividend as written
  assign quot_fix = div_zero ? '1 : (neg_quot ? (~quot_mag + 1'b1) : quot_mag);
  assign rem_fix  = div_zero ? rem_mag : (neg_rem ? (~rem_mag + 1'b1) : rem_mag);

  always_ff @(posedge clk) begin
    if (reset) begin
      quot <= '0;
      rem  <= '0;
      done <= 1'b0;
      dz   <= 1'b0;
    end else if (iter_done) begin
      quot <= quot_fix;
      rem  <= rem_fix;
      done <= 1'b1;
      dz   <= div_zero;
    end else if (start) begin
      // result stays readable, only the flags drop
      done <= 1'b0;
      dz   <= 1'b0;
    end
  end

  // done stays low for the whole run and rises 35 cycles after start
  a_done_after_start : assert property (@(posedge clk) disable iff (reset)
    start |=> !done [*34] ##1 done);

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the divide unit testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module div_tb -o div_sim
./obj_dir/div_sim | tee "$LOG"

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi

/* verification/div_tb.sv */
// directed testbench for the apb divide unit
// expected results come from / and % with the divide-by-zero rule applied

`timescale 1ns/1ps
`include "div_defines.svh"

module div_tb;

  // ----------------------------------------------------------------------
  // run length
  // ----------------------------------------------------------------------

  localparam int RESET_CYCLES = 16;
  // 23 unsigned, 25 signed, 3 divide by zero, 1 busy run
  localparam int NUM_DIVS = 52;
  // load, 32 steps and done plus status polling
  localparam int DIV_CYCLES = 40;
  // three cycles per access, six per division and about a dozen more
  localparam int APB_CYCLES = 3 * (NUM_DIVS * 6 + 12);
  localparam int WATCHDOG_CYCLES = 2 * (NUM_DIVS * DIV_CYCLES + APB_CYCLES + RESET_CYCLES);
  localparam int MAX_POLLS = 30;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`DIV_ADDR_W-1:0] paddr;
  logic [`DIV_W-1:0]      pwdata;
  logic [`DIV_W-1:0]      prdata;
  logic                   pslverr;

  int checks = 0;
  int errors = 0;

  always #50 clk = ~clk;

  div_apb_top dut0 (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // setup cycle then access cycle with the response sampled mid access cycle
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  function automatic logic [31:0] ctrl_word(input div_pkg::div_op_e op);
    logic [31:0] w;
    w = '0;
    w[`DIV_CTRL_START]  = 1'b1;
    w[`DIV_CTRL_SIGNED] = (op == div_pkg::DIV_SIGNED);
    return w;
  endfunction

  // reference quotient and remainder with the riscv rule for a zero divisor
  task automatic ref_div(input logic [31:0] a, input logic [31:0] b,
                         input div_pkg::div_op_e op,
                         output logic [31:0] q, output logic [31:0] r);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    if (b == 32'd0) begin
      q = '1;
      r = a;
    end else if (op == div_pkg::DIV_UNSIGNED) begin
      q = a / b;
      r = a % b;
    end else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
      // signed overflow wraps back to the dividend
      q = a;
      r = '0;
    end else begin
      q = sa / sb;
      r = sa % sb;
    end
  endtask

  task automatic start_div(input logic [31:0] a, input logic [31:0] b,
                           input div_pkg::div_op_e op);
    logic err;
    apb_write(`DIV_REG_OPA, a, err);
    check_value("opa write pslverr", 32'd0, {31'b0, err});
    apb_write(`DIV_REG_OPB, b, err);
    check_value("opb write pslverr", 32'd0, {31'b0, err});
    apb_write(`DIV_REG_CTRL, ctrl_word(op), err);
    check_value("ctrl write pslverr", 32'd0, {31'b0, err});
  endtask

  // poll status until done, then compare status, quotient and remainder
  task automatic finish_div(input logic [31:0] a, input logic [31:0] b,
                            input div_pkg::div_op_e op, input string label);
    logic [31:0] exp_q;
    logic [31:0] exp_r;
    logic [31:0] exp_stat;
    logic [31:0] data;
    logic        err;
    int          polls;
    ref_div(a, b, op, exp_q, exp_r);
    exp_stat = '0;
    exp_stat[`DIV_STAT_DONE] = 1'b1;
    exp_stat[`DIV_STAT_DZ]   = (b == 32'd0);
    polls = 0;
    data  = '0;
    while (!data[`DIV_STAT_DONE] && polls < MAX_POLLS) begin
      apb_read(`DIV_REG_CTRL, data, err);
      polls++;
    end
    if (!data[`DIV_STAT_DONE]) begin
      errors++;
      $display("%s: done flag still low after %0d status reads", label, polls);
    end
    check_value({label, " status"}, exp_stat, data);
    apb_read(`DIV_REG_QUOT, data, err);
    check_value({label, " quot"}, exp_q, data);
    apb_read(`DIV_REG_REM, data, err);
    check_value({label, " rem"}, exp_r, data);
  endtask

  task automatic run_div(input logic [31:0] a, input logic [31:0] b,
                         input div_pkg::div_op_e op, input string label);
    start_div(a, b, op);
    finish_div(a, b, op, label);
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  task automatic test_reset();
    logic [31:0] data;
    logic        err;
    check_value("idle prdata", 32'd0, prdata);
    check_value("idle pslverr", 32'd0, {31'b0, pslverr});
    apb_read(`DIV_REG_CTRL, data, err);
    check_value("reset status", 32'd0, data);
    apb_read(`DIV_REG_QUOT, data, err);
    check_value("reset quot", 32'd0, data);
    apb_read(`DIV_REG_REM, data, err);
    check_value("reset rem", 32'd0, data);
  endtask

  task automatic test_unsigned();
    logic [31:0] a;
    logic [31:0] b;
    run_div(32'd100, 32'd7, div_pkg::DIV_UNSIGNED, "u 100/7");
    run_div(32'hFFFF_FFFF, 32'd1, div_pkg::DIV_UNSIGNED, "u max/1");
    run_div(32'd5, 32'd9, div_pkg::DIV_UNSIGNED, "u 5/9");
    for (int i = 0; i < 20; i++) begin
      a = $urandom();
      // random shift spreads the divisor over all sizes
      b = $urandom() >> ($urandom() % 32);
      run_div(a, b, div_pkg::DIV_UNSIGNED, $sformatf("u rand %0d", i));
    end
  endtask

  task automatic test_signed();
    logic [31:0] a;
    logic [31:0] b;
    run_div(32'd100, 32'd7, div_pkg::DIV_SIGNED, "s +/+");
    run_div(-32'sd100, 32'd7, div_pkg::DIV_SIGNED, "s -/+");
    run_div(32'd100, -32'sd7, div_pkg::DIV_SIGNED, "s +/-");
    run_div(-32'sd100, -32'sd7, div_pkg::DIV_SIGNED, "s -/-");
    run_div(32'h8000_0000, 32'hFFFF_FFFF, div_pkg::DIV_SIGNED, "s min/-1");
    for (int i = 0; i < 20; i++) begin
      a = $urandom();
      b = $urandom() >> ($urandom() % 32);
      run_div(a, b, div_pkg::DIV_SIGNED, $sformatf("s rand %0d", i));
    end
  endtask

  task automatic test_div_zero();
    run_div(-32'sd12345, 32'd0, div_pkg::DIV_SIGNED, "s x/0");
    run_div(32'hDEAD_BEEF, 32'd0, div_pkg::DIV_UNSIGNED, "u x/0");
    // dz must drop again on a normal division
    run_div(32'd81, 32'd9, div_pkg::DIV_UNSIGNED, "after x/0");
  endtask

  task automatic test_errors();
    logic [31:0] data;
    logic        err;
    start_div(32'd1000, 32'd3, div_pkg::DIV_UNSIGNED);
    apb_write(`DIV_REG_CTRL, ctrl_word(div_pkg::DIV_SIGNED), err);
    check_value("busy start pslverr", 32'd1, {31'b0, err});
    // engine already holds its operands so new values only reach the registers
    apb_write(`DIV_REG_OPA, 32'h1234_5678, err);
    check_value("mid run opa pslverr", 32'd0, {31'b0, err});
    apb_write(`DIV_REG_OPB, 32'h0000_00FF, err);
    check_value("mid run opb pslverr", 32'd0, {31'b0, err});
    finish_div(32'd1000, 32'd3, div_pkg::DIV_UNSIGNED, "busy run");
    apb_read(`DIV_REG_OPA, data, err);
    check_value("opa readback", 32'h1234_5678, data);
    apb_read(`DIV_REG_OPB, data, err);
    check_value("opb readback", 32'h0000_00FF, data);
    apb_write(`DIV_REG_QUOT, 32'd0, err);
    check_value("quot write pslverr", 32'd1, {31'b0, err});
    apb_write(`DIV_REG_REM, 32'd0, err);
    check_value("rem write pslverr", 32'd1, {31'b0, err});
    apb_read(`DIV_REG_QUOT, data, err);
    check_value("held quot", 32'd333, data);
    apb_read(`DIV_REG_REM, data, err);
    check_value("held rem", 32'd1, data);
    apb_read(5'h14, data, err);
    check_value("unmapped read pslverr", 32'd1, {31'b0, err});
    check_value("unmapped read prdata", 32'd0, data);
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------

  initial begin
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(2));
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_reset();
    test_unsigned();
    test_signed();
    test_div_zero();
    test_errors();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
